// File: logic/axil_regs.sv
`timescale 1ns/1ps
`include "fir_defs.svh"

module axil_regs (
    input  logic                   axis_clk,
    input  logic                   axis_rst_n,
    input  logic                   awvalid,
    input  logic [`FIR_ADDR_W-1:0] awaddr,
    input  logic                   wvalid,
    input  fir_pkg::data_t         wdata,
    output logic                   awready,
    output logic                   wready,
    input  logic                   arvalid,
    input  logic [`FIR_ADDR_W-1:0] araddr,
    output logic                   arready,
    output logic                   rvalid,
    output fir_pkg::data_t         rdata,
    input  logic                   rready,
    output logic                   start,
    input  logic                   busy,
    input  logic                   tap_rd_en,
    input  fir_pkg::ram_addr_t     tap_rd_addr,
    output fir_pkg::data_t         tap_rd_data,
    ram_if.initiator               tap_bus
);
    import fir_pkg::*;

    axil_state_e            state_q;
    logic [`FIR_ADDR_W-1:0] raddr_q;
    logic                   rd_tick_q;   // tap read already issued
    logic                   rd_busy_q;   // engine owned the tap port at issue
    logic                   ap_start_q;
    logic                   ap_done_q;
    logic                   ap_idle_q;
    logic                   busy_q;
    data_t                  ctrl_word;
    logic                   host_wr;
    logic                   host_rd;
    logic                   ctrl_wr;

    function automatic logic tap_hit(input logic [`FIR_ADDR_W-1:0] a);
        return (a >= `FIR_TAP_BASE) &&
               (a < `FIR_TAP_BASE + (`FIR_NUM_TAPS << 2)) &&
               (a[1:0] == 2'b00);
    endfunction

    // byte offset to tap word
    function automatic ram_addr_t tap_word(input logic [`FIR_ADDR_W-1:0] a);
        logic [`FIR_ADDR_W-1:0] off;
        off = a - `FIR_TAP_BASE;
        return ram_addr_t'(off >> 2);
    endfunction

    assign start       = ap_start_q;   // high for exactly one cycle
    assign tap_rd_data = tap_bus.rdata;

    assign host_wr = (state_q == AXIL_WRITE) && tap_hit(awaddr);
    assign host_rd = (state_q == AXIL_RWAIT) && tap_hit(raddr_q) && !rd_tick_q;
    assign ctrl_wr = (state_q == AXIL_WRITE) && (awaddr == `FIR_AP_CTRL_ADDR);

    always_comb begin
        ctrl_word = '0;
        ctrl_word[`FIR_AP_START_BIT] = ap_start_q;
        ctrl_word[`FIR_AP_DONE_BIT]  = ap_done_q;
        ctrl_word[`FIR_AP_IDLE_BIT]  = ap_idle_q;
    end

    // engine owns the tap port for the whole run
    always_comb begin
        if (busy) begin
            tap_bus.en    = tap_rd_en;
            tap_bus.we    = 1'b0;
            tap_bus.addr  = tap_rd_addr;
            tap_bus.wdata = '0;
        end else begin
            tap_bus.en    = host_wr || host_rd;
            tap_bus.we    = host_wr;
            tap_bus.addr  = host_wr ? tap_word(awaddr) : tap_word(raddr_q);
            tap_bus.wdata = wdata;
        end
    end

    always_ff @(posedge axis_clk) begin
        if (!axis_rst_n) begin
            state_q   <= AXIL_IDLE;
            awready   <= 1'b0;
            wready    <= 1'b0;
            arready   <= 1'b0;
            rvalid    <= 1'b0;
            rd_tick_q <= 1'b0;
            rd_busy_q <= 1'b0;
        end else begin
            case (state_q)
                AXIL_IDLE: begin
                    if (awvalid && wvalid) begin   // write wins a tie
                        awready <= 1'b1;
                        wready  <= 1'b1;
                        state_q <= AXIL_WRITE;
                    end else if (arvalid) begin
                        arready <= 1'b1;
                        state_q <= AXIL_RADDR;
                    end
                end
                AXIL_WRITE: begin
                    awready <= 1'b0;
                    wready  <= 1'b0;
                    state_q <= AXIL_IDLE;
                end
                AXIL_RADDR: begin
                    arready <= 1'b0;
                    state_q <= AXIL_RWAIT;
                end
                AXIL_RWAIT: begin
                    if (tap_hit(raddr_q) && !rd_tick_q) begin
                        rd_tick_q <= 1'b1;   // wait for RAM data
                        rd_busy_q <= busy;
                    end else begin
                        rd_tick_q <= 1'b0;
                        rvalid    <= 1'b1;
                        state_q   <= AXIL_RESP;
                    end
                end
                AXIL_RESP: begin
                    if (rready) begin
                        rvalid  <= 1'b0;
                        state_q <= AXIL_IDLE;
                    end
                end
                default: state_q <= AXIL_IDLE;
            endcase
        end
    end

    // read address and data
    always_ff @(posedge axis_clk) begin
        if (state_q == AXIL_RADDR) begin
            raddr_q <= araddr;
        end
        if (state_q == AXIL_RWAIT) begin
            if (raddr_q == `FIR_AP_CTRL_ADDR) begin
                rdata <= ctrl_word;
            end else if (tap_hit(raddr_q) && rd_tick_q && !rd_busy_q) begin
                rdata <= tap_bus.rdata;
            end else begin
                rdata <= '0;   // unmapped, or tap read during a run
            end
        end
    end

    // ap_start / ap_done / ap_idle
    always_ff @(posedge axis_clk) begin
        if (!axis_rst_n) begin
            ap_start_q <= 1'b0;
            ap_done_q  <= 1'b0;
            ap_idle_q  <= 1'b1;
            busy_q     <= 1'b0;
        end else begin
            busy_q <= busy;
            if (ap_start_q) begin
                ap_start_q <= 1'b0;
                ap_done_q  <= 1'b0;
                ap_idle_q  <= 1'b0;
            end else if (busy_q && !busy) begin   // last output accepted
                ap_done_q <= 1'b1;
                ap_idle_q <= 1'b1;
            end else if (ctrl_wr && wdata[`FIR_AP_START_BIT] && ap_idle_q) begin
                ap_start_q <= 1'b1;
            end
        end
    end

endmodule

// File: logic/fir_defs.svh
`ifndef FIR_DEFS_SVH
`define FIR_DEFS_SVH

// filter size
`define FIR_NUM_TAPS      11

// word and address widths
`define FIR_DATA_W        32
`define FIR_ADDR_W        12
`define FIR_RAM_AW        4     // covers FIR_NUM_TAPS words

// register map, byte offsets
`define FIR_AP_CTRL_ADDR  12'h000
`define FIR_TAP_BASE      12'h020   // tap k at base + 4*k

// control register bits
`define FIR_AP_START_BIT  0
`define FIR_AP_DONE_BIT   1
`define FIR_AP_IDLE_BIT   2

`endif

// File: logic/fir_engine.sv
`timescale 1ns/1ps
`include "fir_defs.svh"

module fir_engine (
    input  logic               axis_clk,
    input  logic               axis_rst_n,
    input  logic               start,
    output logic               busy,
    output logic               tap_rd_en,
    output fir_pkg::ram_addr_t tap_rd_addr,
    input  fir_pkg::data_t     tap_rd_data,
    ram_if.initiator           data_bus,
    input  logic               ss_tvalid,
    input  fir_pkg::data_t     ss_tdata,
    input  logic               ss_tlast,
    output logic               ss_tready,
    output logic               sm_tvalid,
    output fir_pkg::data_t     sm_tdata,
    output logic               sm_tlast,
    input  logic               sm_tready
);
    import fir_pkg::*;

    eng_state_e state_q;
    ram_addr_t  idx_q;      // clear address, then tap index
    ram_addr_t  wr_ptr_q;   // slot for the next sample
    ram_addr_t  hist_q;     // history slot being read
    logic       rd_vld_q;   // RAM data arrives this cycle
    data_t      acc_q;
    logic       last_q;
    data_t      prod;
    logic       issue;
    logic       ss_fire;
    logic       sm_fire;

    function automatic ram_addr_t wrap_inc(input ram_addr_t a);
        return (a == ram_addr_t'(`FIR_NUM_TAPS - 1)) ? '0 : a + 1'b1;
    endfunction

    function automatic ram_addr_t wrap_dec(input ram_addr_t a);
        return (a == '0) ? ram_addr_t'(`FIR_NUM_TAPS - 1) : a - 1'b1;
    endfunction

    assign busy      = (state_q != ENG_IDLE);
    assign ss_tready = (state_q == ENG_WAIT_IN);
    assign sm_tvalid = (state_q == ENG_OUT);
    assign sm_tdata  = acc_q;    // frozen while in ENG_OUT
    assign sm_tlast  = last_q;

    assign ss_fire = ss_tvalid && ss_tready;
    assign sm_fire = sm_tvalid && sm_tready;

    assign issue       = (state_q == ENG_MAC) && (idx_q < ram_addr_t'(`FIR_NUM_TAPS));
    assign tap_rd_en   = issue;
    assign tap_rd_addr = idx_q;

    // signed, wraps to the word width
    assign prod = data_bus.rdata * tap_rd_data;

    always_comb begin
        data_bus.en    = 1'b0;
        data_bus.we    = 1'b0;
        data_bus.addr  = hist_q;
        data_bus.wdata = '0;
        case (state_q)
            ENG_CLEAR: begin
                data_bus.en   = 1'b1;   // zero one history slot
                data_bus.we   = 1'b1;
                data_bus.addr = idx_q;
            end
            ENG_WAIT_IN: begin
                if (ss_fire) begin
                    data_bus.en    = 1'b1;
                    data_bus.we    = 1'b1;
                    data_bus.addr  = wr_ptr_q;
                    data_bus.wdata = ss_tdata;
                end
            end
            ENG_MAC: data_bus.en = issue;
            default: ;
        endcase
    end

    always_ff @(posedge axis_clk) begin
        if (!axis_rst_n) begin
            state_q  <= ENG_IDLE;
            idx_q    <= '0;
            wr_ptr_q <= '0;
            rd_vld_q <= 1'b0;
        end else begin
            rd_vld_q <= issue;
            case (state_q)
                ENG_IDLE: begin
                    if (start) begin
                        idx_q    <= '0;
                        wr_ptr_q <= '0;
                        state_q  <= ENG_CLEAR;
                    end
                end
                ENG_CLEAR: begin
                    if (idx_q == ram_addr_t'(`FIR_NUM_TAPS - 1)) begin
                        state_q <= ENG_WAIT_IN;
                    end else begin
                        idx_q <= idx_q + 1'b1;
                    end
                end
                ENG_WAIT_IN: begin
                    if (ss_fire) begin
                        wr_ptr_q <= wrap_inc(wr_ptr_q);
                        idx_q    <= '0;
                        state_q  <= ENG_MAC;
                    end
                end
                ENG_MAC: begin
                    if (issue) begin
                        idx_q <= idx_q + 1'b1;
                    end else if (rd_vld_q) begin
                        state_q <= ENG_OUT;   // final product lands now
                    end
                end
                ENG_OUT: begin
                    if (sm_fire) begin
                        state_q <= last_q ? ENG_IDLE : ENG_WAIT_IN;
                    end
                end
                default: state_q <= ENG_IDLE;
            endcase
        end
    end

    // accumulator and history walk
    always_ff @(posedge axis_clk) begin
        if (ss_fire) begin
            acc_q  <= '0;
            last_q <= ss_tlast;
            hist_q <= wr_ptr_q;   // newest sample pairs with tap 0
        end
        if (rd_vld_q) begin
            acc_q <= acc_q + prod;
        end
        if (issue) begin
            hist_q <= wrap_dec(hist_q);
        end
    end

endmodule

// File: logic/fir_pkg.sv
`include "fir_defs.svh"

package fir_pkg;

    typedef logic signed [`FIR_DATA_W-1:0] data_t;   // samples, taps, results
    typedef logic [`FIR_RAM_AW-1:0] ram_addr_t;       // RAM word address

    // register slave
    typedef enum logic [2:0] {
        AXIL_IDLE,
        AXIL_WRITE,
        AXIL_RADDR,
        AXIL_RWAIT,
        AXIL_RESP
    } axil_state_e;

    // filter sequencer
    typedef enum logic [2:0] {
        ENG_IDLE,
        ENG_CLEAR,
        ENG_WAIT_IN,
        ENG_MAC,
        ENG_OUT
    } eng_state_e;

endpackage

// File: logic/fir_top.sv
`timescale 1ns/1ps
`include "fir_defs.svh"

module fir_top (
    input  logic                   axis_clk,
    input  logic                   axis_rst_n,
    // register port, write
    input  logic                   awvalid,
    input  logic [`FIR_ADDR_W-1:0] awaddr,
    input  logic                   wvalid,
    input  fir_pkg::data_t         wdata,
    output logic                   awready,
    output logic                   wready,
    // register port, read
    input  logic                   arvalid,
    input  logic [`FIR_ADDR_W-1:0] araddr,
    output logic                   arready,
    output logic                   rvalid,
    output fir_pkg::data_t         rdata,
    input  logic                   rready,
    // sample in
    input  logic                   ss_tvalid,
    input  fir_pkg::data_t         ss_tdata,
    input  logic                   ss_tlast,
    output logic                   ss_tready,
    // result out
    output logic                   sm_tvalid,
    output fir_pkg::data_t         sm_tdata,
    output logic                   sm_tlast,
    input  logic                   sm_tready
);
    import fir_pkg::*;

    logic      start;
    logic      busy;
    logic      tap_rd_en;
    ram_addr_t tap_rd_addr;
    data_t     tap_rd_data;

    ram_if tap_bus ();
    ram_if data_bus ();

    ram_sp #(
        .DEPTH (`FIR_NUM_TAPS),
        .WIDTH (`FIR_DATA_W)
    ) tap_ram_i (
        .axis_clk (axis_clk),
        .mem      (tap_bus)
    );

    ram_sp #(
        .DEPTH (`FIR_NUM_TAPS),
        .WIDTH (`FIR_DATA_W)
    ) data_ram_i (
        .axis_clk (axis_clk),
        .mem      (data_bus)
    );

    axil_regs axil_regs_i (
        .axis_clk    (axis_clk),
        .axis_rst_n  (axis_rst_n),
        .awvalid     (awvalid),
        .awaddr      (awaddr),
        .wvalid      (wvalid),
        .wdata       (wdata),
        .awready     (awready),
        .wready      (wready),
        .arvalid     (arvalid),
        .araddr      (araddr),
        .arready     (arready),
        .rvalid      (rvalid),
        .rdata       (rdata),
        .rready      (rready),
        .start       (start),
        .busy        (busy),
        .tap_rd_en   (tap_rd_en),
        .tap_rd_addr (tap_rd_addr),
        .tap_rd_data (tap_rd_data),
        .tap_bus     (tap_bus)
    );

    fir_engine fir_engine_i (
        .axis_clk    (axis_clk),
        .axis_rst_n  (axis_rst_n),
        .start       (start),
        .busy        (busy),
        .tap_rd_en   (tap_rd_en),
        .tap_rd_addr (tap_rd_addr),
        .tap_rd_data (tap_rd_data),
        .data_bus    (data_bus),
        .ss_tvalid   (ss_tvalid),
        .ss_tdata    (ss_tdata),
        .ss_tlast    (ss_tlast),
        .ss_tready   (ss_tready),
        .sm_tvalid   (sm_tvalid),
        .sm_tdata    (sm_tdata),
        .sm_tlast    (sm_tlast),
        .sm_tready   (sm_tready)
    );

endmodule

// File: logic/ram_if.sv
`timescale 1ns/1ps

// one single-port RAM connection
interface ram_if;
    import fir_pkg::*;

    logic      en;
    logic      we;
    ram_addr_t addr;
    data_t     wdata;
    data_t     rdata;    // valid one cycle after a read

    modport initiator (
        output en,
        output we,
        output addr,
        output wdata,
        input  rdata
    );

    modport memory (
        input  en,
        input  we,
        input  addr,
        input  wdata,
        output rdata
    );

endinterface

// File: logic/ram_sp.sv
`timescale 1ns/1ps

module ram_sp #(
    parameter int DEPTH = 11,
    parameter int WIDTH = 32
) (
    input  logic     axis_clk,
    ram_if.memory    mem
);

    logic [WIDTH-1:0] words [DEPTH];

    // write and registered read share the one port
    always_ff @(posedge axis_clk) begin
        if (mem.en) begin
            if (mem.we) begin
                if (mem.addr < DEPTH) begin
                    words[mem.addr] <= mem.wdata;
                end
            end else begin
                mem.rdata <= words[mem.addr];
            end
        end
    end

endmodule

// File: sim/fir_tb.sv
`timescale 1ns/1ps
`include "fir_defs.svh"

module fir_tb;
    import fir_pkg::*;

    localparam int WAIT_LIMIT  = 2000;   // cycles per wait loop
    localparam int MAX_SAMPLES = 64;

    logic                   axis_clk;
    logic                   axis_rst_n;
    logic                   awvalid;
    logic [`FIR_ADDR_W-1:0] awaddr;
    logic                   wvalid;
    data_t                  wdata;
    logic                   awready;
    logic                   wready;
    logic                   arvalid;
    logic [`FIR_ADDR_W-1:0] araddr;
    logic                   arready;
    logic                   rvalid;
    data_t                  rdata;
    logic                   rready;
    logic                   ss_tvalid;
    data_t                  ss_tdata;
    logic                   ss_tlast;
    logic                   ss_tready;
    logic                   sm_tvalid;
    data_t                  sm_tdata;
    logic                   sm_tlast;
    logic                   sm_tready;

    data_t       tap_val [`FIR_NUM_TAPS];   // taps as written
    data_t       samp [MAX_SAMPLES];        // samples of the current run
    logic [31:0] stim_lfsr;
    logic [31:0] rdy_lfsr;
    logic        bp_mode;                   // random sm_tready when set
    int          run_len;
    int          out_cnt;
    int          err_cnt;                   // main sequence
    int          chk_err;                   // output checker
    int          test_cnt;
    int          test_fail;
    data_t       exp_val;

    fir_top fir_top_i (.*);

    initial begin
        axis_clk = 1'b0;
        forever #2 axis_clk = ~axis_clk;
    end

    // fibonacci lfsr with taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic get_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            stim_lfsr = lfsr_next(stim_lfsr);
            v = {v[30:0], stim_lfsr[0]};
        end
    endtask

    // y[n] = sum of tap k times x[n-k] where older samples count as zero
    function automatic data_t fir_ref(input int n);
        data_t acc;
        acc = '0;
        for (int k = 0; k < `FIR_NUM_TAPS; k++) begin
            if (n - k >= 0) begin
                acc = acc + tap_val[k] * samp[n - k];   // wraps to 32 bits
            end
        end
        return acc;
    endfunction

    task automatic finish_sim();
        $display("%0d tests run, %0d with errors, %0d errors in total",
                 test_cnt, test_fail, err_cnt + chk_err);
        if (err_cnt + chk_err == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    endtask

    task automatic timeout_abort(input string what);
        $display("ERROR at %0t: gave up waiting for %s", $time, what);
        err_cnt++;
        finish_sim();
    endtask

    task automatic expect_eq(input string name, input data_t got, input data_t exp);
        if (got !== exp) begin
            $display("FAIL %0t %s expected %h got %h", $time, name, exp, got);
            err_cnt++;
        end
    endtask

    task automatic end_test(input string name, input int errs_before);
        test_cnt++;
        if (err_cnt + chk_err != errs_before) begin
            test_fail++;
            $display("test %0d %s: %0d errors", test_cnt, name,
                     err_cnt + chk_err - errs_before);
        end else begin
            $display("test %0d %s: ok", test_cnt, name);
        end
    endtask

    task automatic axil_write(input logic [`FIR_ADDR_W-1:0] addr, input data_t data);
        int   waited;
        logic seen;
        awaddr  = addr;
        wdata   = data;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        waited  = 0;
        seen    = 1'b0;
        while (!seen) begin
            @(posedge axis_clk);
            seen = awready && wready;   // write lands on this edge
            #1;
            waited++;
            if (!seen && waited > WAIT_LIMIT) timeout_abort("awready and wready");
        end
        awvalid = 1'b0;
        wvalid  = 1'b0;
    endtask

    task automatic axil_read(input logic [`FIR_ADDR_W-1:0] addr, output data_t data);
        int   waited;
        logic seen;
        araddr  = addr;
        arvalid = 1'b1;
        waited  = 0;
        seen    = 1'b0;
        while (!seen) begin
            @(posedge axis_clk);
            seen = arready;
            #1;
            waited++;
            if (!seen && waited > WAIT_LIMIT) timeout_abort("arready");
        end
        arvalid = 1'b0;
        rready  = 1'b1;
        waited  = 0;
        seen    = 1'b0;
        while (!seen) begin
            @(posedge axis_clk);
            seen = rvalid;
            data = rdata;
            #1;
            waited++;
            if (!seen && waited > WAIT_LIMIT) timeout_abort("rvalid");
        end
        rready = 1'b0;
    endtask

    // fresh samples and then the start command
    task automatic start_run(input int n, input logic bp);
        logic [31:0] v;
        for (int i = 0; i < n; i++) begin
            get_bits(32, v);
            samp[i] = v;
        end
        run_len = n;
        out_cnt = 0;
        bp_mode = bp;
        axil_write(`FIR_AP_CTRL_ADDR, 32'h1);
    endtask

    task automatic stream_samples(input int n, input logic gaps);
        int          waited;
        logic        seen;
        logic [31:0] g;
        for (int i = 0; i < n; i++) begin
            if (gaps) begin
                get_bits(5, g);   // long enough to outlast the MAC loop
                repeat (g) begin
                    @(posedge axis_clk);
                    #1;
                end
            end
            ss_tdata  = samp[i];
            ss_tlast  = (i == n - 1);
            ss_tvalid = 1'b1;
            waited    = 0;
            seen      = 1'b0;
            while (!seen) begin
                @(posedge axis_clk);
                seen = ss_tready;
                #1;
                waited++;
                if (!seen && waited > WAIT_LIMIT) timeout_abort("ss_tready");
            end
            ss_tvalid = 1'b0;
            ss_tlast  = 1'b0;
        end
    endtask

    task automatic wait_outputs(input int n);
        int waited;
        waited = 0;
        while (out_cnt < n) begin
            @(posedge axis_clk);
            #1;
            waited++;
            if (waited > WAIT_LIMIT) timeout_abort("the final output");
        end
        repeat (20) @(posedge axis_clk);   // room for a stray extra output
        #1;
        bp_mode = 1'b0;
        if (out_cnt != n) begin
            $display("FAIL %0t output count expected %0d got %0d", $time, n, out_cnt);
            err_cnt++;
        end
    endtask

    // output side ready pattern
    always @(posedge axis_clk) begin
        #1;
        if (bp_mode) begin
            rdy_lfsr  = lfsr_next(rdy_lfsr);
            sm_tready = rdy_lfsr[0];
        end else begin
            sm_tready = 1'b1;
        end
    end

    // compare every accepted output with the model
    always @(posedge axis_clk) begin
        if (axis_rst_n && sm_tvalid && sm_tready) begin
            if (out_cnt >= run_len) begin
                $display("ERROR at %0t: output beyond the %0d expected", $time, run_len);
                chk_err++;
            end else begin
                exp_val = fir_ref(out_cnt);
                if (sm_tdata !== exp_val) begin
                    $display("FAIL %0t sm_tdata[%0d] expected %h got %h",
                             $time, out_cnt, exp_val, sm_tdata);
                    chk_err++;
                end
                if (sm_tlast !== (out_cnt == run_len - 1)) begin
                    $display("FAIL %0t sm_tlast[%0d] expected %b got %b",
                             $time, out_cnt, (out_cnt == run_len - 1), sm_tlast);
                    chk_err++;
                end
            end
            out_cnt++;
        end
    end

    initial begin
        data_t       rd;
        logic [31:0] v;
        int          errs;
        axis_rst_n = 1'b0;
        awvalid    = 1'b0;
        awaddr     = '0;
        wvalid     = 1'b0;
        wdata      = '0;
        arvalid    = 1'b0;
        araddr     = '0;
        rready     = 1'b0;
        ss_tvalid  = 1'b0;
        ss_tdata   = '0;
        ss_tlast   = 1'b0;
        sm_tready  = 1'b1;
        stim_lfsr  = 32'h9c4e_22b9;
        rdy_lfsr   = 32'h9c4e_22b9;
        bp_mode    = 1'b0;
        run_len    = 0;
        out_cnt    = 0;
        err_cnt    = 0;
        chk_err    = 0;
        test_cnt   = 0;
        test_fail  = 0;
        repeat (16) @(posedge axis_clk);
        #1;
        axis_rst_n = 1'b1;

        errs = err_cnt + chk_err;
        axil_read(`FIR_AP_CTRL_ADDR, rd);
        expect_eq("ap_ctrl", rd, 32'h4);   // idle only
        expect_eq("sm_tvalid", {31'b0, sm_tvalid}, 32'h0);
        end_test("reset values", errs);

        errs = err_cnt + chk_err;
        for (int k = 0; k < `FIR_NUM_TAPS; k++) begin
            get_bits(8, v);
            tap_val[k] = {{24{v[7]}}, v[7:0]};   // small signed taps
            axil_write(`FIR_TAP_BASE + 4 * k, tap_val[k]);
        end
        for (int k = 0; k < `FIR_NUM_TAPS; k++) begin
            axil_read(`FIR_TAP_BASE + 4 * k, rd);
            expect_eq($sformatf("tap[%0d]", k), rd, tap_val[k]);
        end
        end_test("tap write and read back", errs);

        errs = err_cnt + chk_err;
        start_run(40, 1'b0);
        stream_samples(40, 1'b0);
        wait_outputs(40);
        end_test("plain stream run", errs);

        errs = err_cnt + chk_err;
        start_run(40, 1'b1);
        stream_samples(40, 1'b1);
        wait_outputs(40);
        end_test("run with gaps and back-pressure", errs);

        errs = err_cnt + chk_err;
        axil_read(`FIR_AP_CTRL_ADDR, rd);
        expect_eq("ap_ctrl", rd, 32'h6);   // done and idle
        start_run(25, 1'b0);
        stream_samples(25, 1'b0);
        wait_outputs(25);
        end_test("done flags and cleared history", errs);

        errs = err_cnt + chk_err;
        start_run(15, 1'b0);
        axil_write(`FIR_TAP_BASE + 12, tap_val[3] + 32'd100);   // engine owns taps now
        axil_read(`FIR_TAP_BASE + 20, rd);
        expect_eq("tap[5] while busy", rd, 32'h0);
        stream_samples(15, 1'b0);
        wait_outputs(15);
        axil_read(`FIR_TAP_BASE + 12, rd);
        expect_eq("tap[3] after run", rd, tap_val[3]);
        end_test("tap access while busy", errs);

        finish_sim();
    end

endmodule

// File: vlog.f
+incdir+logic
logic/fir_pkg.sv
logic/ram_if.sv
logic/ram_sp.sv
logic/axil_regs.sv
logic/fir_engine.sv
logic/fir_top.sv
sim/fir_tb.sv
